//--- include/i2c_target_defs.svh
// i2c target constants: bus address, input debounce, bit hold time, rx credits
`ifndef I2C_TARGET_DEFS_SVH
`define I2C_TARGET_DEFS_SVH

// 7-bit target address
`define I2C_ADDR 7'h2A

// backoff cycles once a filtered input has changed
`define I2C_DEBOUNCE 7

// cycles after scl falls before a bit is done, 20% of a 100 kHz bit at 10 MHz
`define I2C_HOLD_CYCLES 20

// receive credits after reset, also the ceiling
`define I2C_RX_CREDITS 4

`endif

//--- verilog/i2c_pkg.sv
// shared types for the i2c target: data byte, ack level and FSM states
package i2c_pkg;

  typedef logic [7:0] i2c_byte_t;

  typedef enum logic {
    ACK  = 1'b0,  // sda pulled low
    NACK = 1'b1   // sda left high
  } i2c_ack_e;

  typedef enum logic [3:0] {
    IDLE,
    ADDR_READ,
    ADDR_PROC,
    ACK_SEND,
    ACK_WAIT,
    WORD_READ,
    WORD_PROC,
    WORD_SEND,
    WORD_WAIT,
    ACK_READ,
    ACK_PROC
  } byte_state_e;

  // prefixed, literals share the package scope with byte_state_e
  typedef enum logic [2:0] {
    PHY_IDLE,
    PHY_TX_EDGE,
    PHY_RX_RISE,
    PHY_RX_FALL,
    PHY_HOLD
  } phy_state_e;

endpackage

//--- verilog/i2c_bit_if.sv
// bit-level handshake between the byte engine and the bit driver/sampler
interface i2c_bit_if;

  logic send_req;   // one-cycle, send send_bit
  logic send_bit;
  logic send_last;  // release sda after this bit
  logic get_req;    // one-cycle, sample a bit
  logic sent;       // hold time of sent bit over
  logic got;        // hold time of sampled bit over
  logic rx_bit;

  modport engine (
    output send_req, send_bit, send_last, get_req,
    input  sent, got, rx_bit
  );

  modport phy (
    input  send_req, send_bit, send_last, get_req,
    output sent, got, rx_bit
  );

endinterface

//--- verilog/i2c_line_decode.sv
// i2c line decoder: debounces scl/sda, finds edges, START/STOP and bus busy
`include "i2c_target_defs.svh"

module i2c_line_decode (
  input  logic clk,
  input  logic reset,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_rise_o,
  output logic scl_fall_o,
  output logic start_o,
  output logic stop_o,
  output logic sda_o,
  output logic busy_o
);

  localparam int CNT_W = $clog2(`I2C_DEBOUNCE + 1);

  logic [1:0]            raw;       // {scl, sda}
  logic [1:0]            filt_q;
  logic [1:0]            prev_q;
  logic [1:0][CNT_W-1:0] backoff_q;
  logic                  scl_rise;
  logic                  scl_fall;
  logic                  sda_rise;
  logic                  sda_fall;

  assign raw = {scl_i, sda_i};

  always_ff @(posedge clk) begin
    if (reset) begin
      filt_q    <= 2'b11;  // idle bus is high
      backoff_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (backoff_q[i] != '0) begin
          backoff_q[i] <= backoff_q[i] - CNT_W'(1);
        end else if (raw[i] != filt_q[i]) begin
          filt_q[i]    <= raw[i];
          backoff_q[i] <= CNT_W'(`I2C_DEBOUNCE);
        end
      end
    end
  end

  assign scl_rise = filt_q[1] & ~prev_q[1];
  assign scl_fall = ~filt_q[1] & prev_q[1];
  assign sda_rise = filt_q[0] & ~prev_q[0];
  assign sda_fall = ~filt_q[0] & prev_q[0];

  always_ff @(posedge clk) begin
    if (reset) begin
      prev_q     <= 2'b11;
      scl_rise_o <= 1'b0;
      scl_fall_o <= 1'b0;
      start_o    <= 1'b0;
      stop_o     <= 1'b0;
      busy_o     <= 1'b0;
    end else begin
      prev_q     <= filt_q;
      scl_rise_o <= scl_rise;
      scl_fall_o <= scl_fall;
      start_o    <= sda_fall & filt_q[1];  // sda falls, scl high
      stop_o     <= sda_rise & filt_q[1];
      if (sda_fall && filt_q[1]) begin
        busy_o <= 1'b1;
      end else if (sda_rise && filt_q[1]) begin
        busy_o <= 1'b0;
      end
    end
  end

  assign sda_o = filt_q[0];

endmodule

//--- verilog/i2c_bit_phy.sv
// i2c bit driver/sampler: puts one bit on sda or samples one at scl rise
`include "i2c_target_defs.svh"

module i2c_bit_phy (
  input  logic      clk,
  input  logic      reset,
  input  logic      scl_rise_i,
  input  logic      scl_fall_i,
  input  logic      cond_i,     // START or STOP
  input  logic      sda_i,
  i2c_bit_if.phy    bit_if,
  output logic      sda_oen_o   // low pulls sda down
);

  import i2c_pkg::*;

  localparam int HOLD_W = $clog2(`I2C_HOLD_CYCLES + 1);

  phy_state_e        state_q;
  logic [HOLD_W-1:0] hold_q;
  logic              tx_q;      // bit in flight is outbound
  logic              last_q;

  // hold counts from scl_fall, pulse lands HOLD_CYCLES+1 later
  always_ff @(posedge clk) begin
    bit_if.sent <= 1'b0;
    bit_if.got  <= 1'b0;
    if (reset || cond_i) begin
      state_q   <= PHY_IDLE;
      hold_q    <= '0;
      tx_q      <= 1'b0;
      last_q    <= 1'b0;
      sda_oen_o <= 1'b1;  // let go of the bus
    end else begin
      case (state_q)
        PHY_IDLE: begin
          if (bit_if.send_req) begin
            sda_oen_o <= bit_if.send_bit;
            last_q    <= bit_if.send_last;
            tx_q      <= 1'b1;
            state_q   <= PHY_TX_EDGE;
          end else if (bit_if.get_req) begin
            tx_q    <= 1'b0;
            state_q <= PHY_RX_RISE;
          end
        end
        PHY_TX_EDGE: begin
          if (scl_fall_i) begin
            hold_q  <= HOLD_W'(`I2C_HOLD_CYCLES - 1);
            state_q <= PHY_HOLD;
          end
        end
        PHY_RX_RISE: begin
          if (scl_rise_i) begin
            bit_if.rx_bit <= sda_i;
            state_q       <= PHY_RX_FALL;
          end
        end
        PHY_RX_FALL: begin
          if (scl_fall_i) begin
            hold_q  <= HOLD_W'(`I2C_HOLD_CYCLES - 1);
            state_q <= PHY_HOLD;
          end
        end
        PHY_HOLD: begin
          if (hold_q != '0) begin
            hold_q <= hold_q - HOLD_W'(1);
          end else begin
            if (tx_q) begin
              bit_if.sent <= 1'b1;
              if (last_q) begin
                sda_oen_o <= 1'b1;
              end
            end else begin
              bit_if.got <= 1'b1;
            end
            state_q <= PHY_IDLE;
          end
        end
        default: state_q <= PHY_IDLE;
      endcase
    end
  end

endmodule

//--- verilog/i2c_byte_engine.sv
// i2c byte engine: address match, ACK generation, write and read byte phases
`include "i2c_target_defs.svh"

module i2c_byte_engine (
  input  logic               clk,
  input  logic               reset,
  input  logic               start_i,
  input  logic               stop_i,
  input  logic               busy_i,
  input  logic               has_credit_i,
  input  i2c_pkg::i2c_byte_t tx_byte_i,
  i2c_bit_if.engine          bit_if,
  output logic               rx_push_o,
  output logic               tx_pop_o,
  output logic               cmd_strb_o,
  output logic               cmd_rw_o,
  output i2c_pkg::i2c_byte_t rx_byte_o
);

  import i2c_pkg::*;

  byte_state_e state_q;
  logic [6:0]  shift_q;
  logic [2:0]  idx_q;
  logic        rw_q;        // 1 = read
  logic        addr_phase_q;
  i2c_ack_e    ack_q;
  logic        last_bit;
  i2c_byte_t   rx_word;

  assign last_bit  = (idx_q == 3'd7);
  assign rx_word   = {shift_q, bit_if.rx_bit};
  assign rx_byte_o = rx_word;
  // push lands with the eighth got pulse, so the ACK already knows the credit
  assign rx_push_o = (state_q == WORD_PROC) && bit_if.got && last_bit && has_credit_i;
  assign cmd_rw_o  = rw_q;

  always_ff @(posedge clk) begin
    bit_if.send_req <= 1'b0;
    bit_if.get_req  <= 1'b0;
    tx_pop_o        <= 1'b0;
    cmd_strb_o      <= 1'b0;
    if (reset || start_i || stop_i) begin
      state_q      <= ADDR_READ;
      idx_q        <= '0;
      rw_q         <= 1'b0;
      addr_phase_q <= 1'b1;
    end else if (busy_i) begin
      case (state_q)
        IDLE: ;  // wait for the next START
        ADDR_READ: begin
          bit_if.get_req <= 1'b1;
          state_q        <= ADDR_PROC;
        end
        ADDR_PROC: begin
          if (bit_if.got) begin
            shift_q <= rx_word[6:0];
            if (last_bit) begin
              rw_q         <= bit_if.rx_bit;
              idx_q        <= '0;
              addr_phase_q <= 1'b1;
              ack_q        <= ACK;
              state_q      <= (shift_q == `I2C_ADDR) ? ACK_SEND : IDLE;
            end else begin
              idx_q   <= idx_q + 3'd1;
              state_q <= ADDR_READ;
            end
          end
        end
        ACK_SEND: begin
          bit_if.send_req  <= 1'b1;
          bit_if.send_bit  <= ack_q;
          bit_if.send_last <= addr_phase_q ? ~rw_q : 1'b1;  // read keeps sda for bit 7
          state_q          <= ACK_WAIT;
        end
        ACK_WAIT: begin
          if (bit_if.sent) begin
            idx_q <= '0;
            if (addr_phase_q) begin
              cmd_strb_o   <= 1'b1;
              addr_phase_q <= 1'b0;
              state_q      <= rw_q ? WORD_SEND : WORD_READ;
            end else begin
              state_q <= WORD_READ;
            end
          end
        end
        WORD_READ: begin
          bit_if.get_req <= 1'b1;
          state_q        <= WORD_PROC;
        end
        WORD_PROC: begin
          if (bit_if.got) begin
            shift_q <= rx_word[6:0];
            if (last_bit) begin
              ack_q   <= has_credit_i ? ACK : NACK;  // no credit, refuse the byte
              state_q <= ACK_SEND;
            end else begin
              idx_q   <= idx_q + 3'd1;
              state_q <= WORD_READ;
            end
          end
        end
        WORD_SEND: begin
          bit_if.send_req  <= 1'b1;
          bit_if.send_bit  <= tx_byte_i[3'd7 - idx_q];  // msb first
          bit_if.send_last <= last_bit;
          tx_pop_o         <= last_bit;
          state_q          <= WORD_WAIT;
        end
        WORD_WAIT: begin
          if (bit_if.sent) begin
            if (last_bit) begin
              idx_q   <= '0;
              state_q <= ACK_READ;
            end else begin
              idx_q   <= idx_q + 3'd1;
              state_q <= WORD_SEND;
            end
          end
        end
        ACK_READ: begin
          bit_if.get_req <= 1'b1;
          state_q        <= ACK_PROC;
        end
        ACK_PROC: begin
          if (bit_if.got) begin
            state_q <= (i2c_ack_e'(bit_if.rx_bit) == NACK) ? IDLE : WORD_SEND;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

endmodule

//--- verilog/i2c_byte_port.sv
// i2c byte port: rx credit counter and output register, tx holding register
`include "i2c_target_defs.svh"

module i2c_byte_port (
  input  logic               clk,
  input  logic               reset,
  input  logic               rx_push_i,
  input  logic               tx_pop_i,
  input  logic               rx_credit_i,
  input  logic               tx_valid_i,
  input  i2c_pkg::i2c_byte_t rx_byte_i,
  input  i2c_pkg::i2c_byte_t tx_data_i,
  output logic               has_credit_o,
  output logic               rx_valid_o,
  output logic               tx_busy_o,
  output i2c_pkg::i2c_byte_t rx_data_o,
  output i2c_pkg::i2c_byte_t tx_byte_o
);

  import i2c_pkg::*;

  localparam int                CRED_W   = $clog2(`I2C_RX_CREDITS + 1);
  localparam logic [CRED_W-1:0] CRED_MAX = CRED_W'(`I2C_RX_CREDITS);

  logic [CRED_W-1:0] credit_q;
  i2c_byte_t         tx_q;
  logic              busy_q;

  assign has_credit_o = (credit_q != '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      credit_q   <= CRED_MAX;
      rx_valid_o <= 1'b0;
    end else begin
      rx_valid_o <= rx_push_i;
      if (rx_push_i && !rx_credit_i) begin
        credit_q <= credit_q - CRED_W'(1);
      end else if (rx_credit_i && !rx_push_i && credit_q != CRED_MAX) begin
        credit_q <= credit_q + CRED_W'(1);  // saturates at max
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rx_push_i) begin
      rx_data_o <= rx_byte_i;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      tx_q   <= 8'h00;
      busy_q <= 1'b0;
    end else if (tx_pop_i) begin
      tx_q   <= 8'h00;  // empty register reads back as zero
      busy_q <= 1'b0;
    end else if (tx_valid_i) begin
      tx_q   <= tx_data_i;
      busy_q <= 1'b1;
    end
  end

  assign tx_byte_o = tx_q;
  assign tx_busy_o = tx_valid_i | busy_q;

endmodule

//--- verilog/i2c_target_top.sv
// i2c target top: line decoder, byte engine, bit phy and local byte port
module i2c_target_top (
  input  logic               clk,
  input  logic               reset,
  input  logic               scl_i,
  input  logic               sda_i,
  input  logic               rx_credit_i,
  input  logic               tx_valid_i,
  input  i2c_pkg::i2c_byte_t tx_data_i,
  output logic               sda_oen_o,
  output logic               rx_valid_o,
  output logic               tx_busy_o,
  output logic               cmd_strb_o,
  output logic               cmd_rw_o,
  output i2c_pkg::i2c_byte_t rx_data_o
);

  import i2c_pkg::*;

  logic      scl_rise;
  logic      scl_fall;
  logic      start_det;
  logic      stop_det;
  logic      sda_q;
  logic      bus_busy;
  logic      has_credit;
  logic      rx_push;
  logic      tx_pop;
  i2c_byte_t rx_byte;
  i2c_byte_t tx_byte;

  i2c_bit_if bit_if ();

  i2c_line_decode u_decode (
    .clk        (clk),
    .reset      (reset),
    .scl_i      (scl_i),
    .sda_i      (sda_i),
    .scl_rise_o (scl_rise),
    .scl_fall_o (scl_fall),
    .start_o    (start_det),
    .stop_o     (stop_det),
    .sda_o      (sda_q),
    .busy_o     (bus_busy)
  );

  i2c_byte_engine u_engine (
    .clk          (clk),
    .reset        (reset),
    .start_i      (start_det),
    .stop_i       (stop_det),
    .busy_i       (bus_busy),
    .has_credit_i (has_credit),
    .tx_byte_i    (tx_byte),
    .bit_if       (bit_if.engine),
    .rx_push_o    (rx_push),
    .tx_pop_o     (tx_pop),
    .cmd_strb_o   (cmd_strb_o),
    .cmd_rw_o     (cmd_rw_o),
    .rx_byte_o    (rx_byte)
  );

  i2c_bit_phy u_phy (
    .clk        (clk),
    .reset      (reset),
    .scl_rise_i (scl_rise),
    .scl_fall_i (scl_fall),
    .cond_i     (start_det | stop_det),
    .sda_i      (sda_q),
    .bit_if     (bit_if.phy),
    .sda_oen_o  (sda_oen_o)
  );

  i2c_byte_port u_port (
    .clk          (clk),
    .reset        (reset),
    .rx_push_i    (rx_push),
    .tx_pop_i     (tx_pop),
    .rx_credit_i  (rx_credit_i),
    .tx_valid_i   (tx_valid_i),
    .rx_byte_i    (rx_byte),
    .tx_data_i    (tx_data_i),
    .has_credit_o (has_credit),
    .rx_valid_o   (rx_valid_o),
    .tx_busy_o    (tx_busy_o),
    .rx_data_o    (rx_data_o),
    .tx_byte_o    (tx_byte)
  );

endmodule

//--- tests/tb_clock_gen.sv
// testbench clock and reset source, 20-unit period with reset held for three cycles
module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  localparam int HALF_PERIOD = 10;

  initial begin
    clk_o   = 1'b0;
    reset_o = 1'b1;
    repeat (3) @(posedge clk_o);
    reset_o <= 1'b0;
  end

  always #HALF_PERIOD clk_o = ~clk_o;

endmodule

//--- tests/i2c_target_tb.sv
// i2c target testbench with controller model, random traffic, reference model and checks
`include "i2c_target_defs.svh"

module i2c_target_tb;

  import i2c_pkg::*;

  localparam int HALF      = 50;  // clocks per scl phase
  localparam int MAX_BYTES = 38;  // worst case over all tests
  localparam int XFERS     = 7;   // start/stop framing at one byte time each
  localparam int LIMIT     = (MAX_BYTES + XFERS) * 9 * 100 + 2000;

  logic      clk;
  logic      reset;
  logic      scl_m;
  logic      sda_m;
  logic      sda_bus;
  logic      rx_credit;
  logic      tx_valid;
  i2c_byte_t tx_data;
  logic      sda_oen;
  logic      rx_valid;
  logic      tx_busy;
  logic      cmd_strb;
  logic      cmd_rw;
  i2c_byte_t rx_data;

  int        credit_model;
  i2c_byte_t tx_model;
  i2c_byte_t rx_exp[$];
  i2c_byte_t mon_exp;
  int        cmd_count;
  logic      cmd_rw_seen;
  int        tests;
  int        checks;
  int        errs;
  int        cycles = 0;
  string     cur_test;

  assign sda_bus = sda_m & sda_oen;  // open-drain wired-AND

  tb_clock_gen u_clk (
    .clk_o   (clk),
    .reset_o (reset)
  );

  i2c_target_top u_dut (
    .clk         (clk),
    .reset       (reset),
    .scl_i       (scl_m),
    .sda_i       (sda_bus),
    .rx_credit_i (rx_credit),
    .tx_valid_i  (tx_valid),
    .tx_data_i   (tx_data),
    .sda_oen_o   (sda_oen),
    .rx_valid_o  (rx_valid),
    .tx_busy_o   (tx_busy),
    .cmd_strb_o  (cmd_strb),
    .cmd_rw_o    (cmd_rw),
    .rx_data_o   (rx_data)
  );

  task automatic report_error(input string name, input string msg);
    errs++;
    $display("ERROR %s: %s", name, msg);
  endtask

  task automatic check_byte(input string name, input i2c_byte_t exp, input i2c_byte_t act);
    checks++;
    if (act !== exp) begin
      errs++;
      $display("MISMATCH %s: expected 8'h%02h, actual 8'h%02h", name, exp, act);
    end
  endtask

  task automatic check_ack(input string name, input i2c_ack_e exp, input i2c_ack_e act);
    checks++;
    if (act !== exp) begin
      errs++;
      $display("MISMATCH %s: expected %s, actual %s", name, exp.name(), act.name());
    end
  endtask

  task automatic check_cmd(input string name, input int count_before, input logic strobe_exp,
                           input logic exp_rw);
    checks++;
    if (!strobe_exp && cmd_count != count_before) begin
      report_error(name, "cmd_strb_o pulsed without an address match");
    end else if (strobe_exp && cmd_count != count_before + 1) begin
      report_error(name, "cmd_strb_o did not pulse once after the address ACK");
    end else if (strobe_exp && cmd_rw_seen !== exp_rw) begin
      errs++;
      $display("MISMATCH %s cmd_rw: expected %b, actual %b", name, exp_rw, cmd_rw_seen);
    end
  endtask

  task automatic report_test(input string name, input int mark);
    tests++;
    $display("%-14s %s", name, (errs == mark) ? "ok" : "FAIL");
  endtask

  task automatic wait_clks(input int n);
    repeat (n) @(posedge clk);
  endtask

  // sda set mid-low and bus sampled late in the high phase
  task automatic clock_bit(input logic b, output logic s);
    wait_clks(HALF / 2);
    sda_m <= b;
    wait_clks(HALF / 2);
    scl_m <= 1'b1;
    wait_clks(HALF - 1);
    @(negedge clk);
    s = sda_bus;
    @(posedge clk);
    scl_m <= 1'b0;
  endtask

  task automatic start_cond();
    @(posedge clk);
    sda_m <= 1'b0;
    wait_clks(HALF);
    scl_m <= 1'b0;
  endtask

  task automatic stop_cond();
    wait_clks(HALF / 2);
    sda_m <= 1'b0;
    wait_clks(HALF / 2);
    scl_m <= 1'b1;
    wait_clks(HALF);
    sda_m <= 1'b1;  // sda rises with scl high
    wait_clks(HALF);
  endtask

  task automatic send_byte(input i2c_byte_t b, output i2c_ack_e ack);
    logic s;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(b[i], s);
    end
    clock_bit(1'b1, s);
    ack = i2c_ack_e'(s);
  endtask

  task automatic recv_byte(input i2c_ack_e ack, output i2c_byte_t b);
    logic s;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(1'b1, s);
      b[i] = s;
    end
    clock_bit(ack, s);
  endtask

  task automatic return_credits(input int n);
    repeat (n) begin
      wait_clks(1 + $urandom % 8);
      rx_credit <= 1'b1;
      @(posedge clk);
      rx_credit <= 1'b0;
      if (credit_model < `I2C_RX_CREDITS) begin
        credit_model++;
      end
    end
  endtask

  task automatic load_tx(input i2c_byte_t d);
    @(posedge clk);
    tx_valid <= 1'b1;
    tx_data  <= d;
    @(negedge clk);
    if (tx_busy !== 1'b1) begin
      report_error(cur_test, "tx_busy_o not raised while tx_valid_i is high");
    end
    @(posedge clk);
    tx_valid <= 1'b0;
    tx_model = d;
  endtask

  task automatic write_xfer(input string name, input logic [6:0] addr, input int n);
    i2c_ack_e  ack;
    i2c_ack_e  exp_ack;
    i2c_byte_t d;
    logic      hit;
    int        cmd_before;
    cmd_before = cmd_count;
    hit = (addr == `I2C_ADDR);
    start_cond();
    send_byte({addr, 1'b0}, ack);
    check_ack({name, " addr"}, hit ? ACK : NACK, ack);
    for (int i = 0; hit && i < n; i++) begin
      d = i2c_byte_t'($urandom);
      exp_ack = (credit_model > 0) ? ACK : NACK;  // no credit means refuse
      if (credit_model > 0) begin
        credit_model--;
        rx_exp.push_back(d);
      end
      send_byte(d, ack);
      check_ack($sformatf("%s data %0d", name, i), exp_ack, ack);
    end
    stop_cond();
    check_cmd(name, cmd_before, hit, 1'b0);
    if (rx_exp.size() != 0) begin
      report_error(name, "accepted bytes never came out on rx_data_o");
      rx_exp.delete();
    end
  endtask

  task automatic read_xfer(input string name, input int n);
    i2c_ack_e  ack;
    i2c_byte_t b;
    int        cmd_before;
    cmd_before = cmd_count;
    start_cond();
    send_byte({`I2C_ADDR, 1'b1}, ack);
    check_ack({name, " addr"}, ACK, ack);
    for (int i = 0; i < n; i++) begin
      recv_byte((i == n - 1) ? NACK : ACK, b);
      check_byte($sformatf("%s byte %0d", name, i), tx_model, b);
      tx_model = 8'h00;  // register empties once sent
    end
    wait_clks(HALF);
    @(negedge clk);
    check_ack({name, " sda release"}, NACK, i2c_ack_e'(sda_oen));
    stop_cond();
    check_cmd(name, cmd_before, 1'b1, 1'b1);
  endtask

  always @(negedge clk) begin
    if (!reset && rx_valid) begin
      if (rx_exp.size() == 0) begin
        report_error(cur_test, "rx_valid_o pulsed with no byte expected");
      end else begin
        mon_exp = rx_exp.pop_front();
        check_byte({cur_test, " rx_data"}, mon_exp, rx_data);
      end
    end
    if (!reset && cmd_strb) begin
      cmd_count++;
      cmd_rw_seen = cmd_rw;
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout: run still going after %0d cycles", LIMIT);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int         n;
    int         mark;
    int         cmd_mark;
    logic       s;
    logic [6:0] bad_addr;
    i2c_ack_e   ack;
    scl_m        = 1'b1;
    sda_m        = 1'b1;
    rx_credit    = 1'b0;
    tx_valid     = 1'b0;
    tx_data      = 8'h00;
    credit_model = `I2C_RX_CREDITS;
    tx_model     = 8'h00;
    cmd_count    = 0;
    tests        = 0;
    checks       = 0;
    errs         = 0;
    cur_test     = "reset";
    n = $urandom(27);  // seed once
    @(negedge reset);
    wait_clks(10);

    cur_test = "write";
    mark = errs;
    write_xfer(cur_test, `I2C_ADDR, 1 + $urandom % 6);
    report_test(cur_test, mark);

    cur_test = "bad address";
    mark = errs;
    bad_addr = 7'($urandom);
    if (bad_addr == `I2C_ADDR) begin
      bad_addr = bad_addr ^ 7'h01;
    end
    write_xfer(cur_test, bad_addr, 1);
    report_test(cur_test, mark);

    // overrun the credits and hand some back
    cur_test = "no credit";
    mark = errs;
    write_xfer(cur_test, `I2C_ADDR, credit_model + 1 + $urandom % 2);
    return_credits(1 + $urandom % 4);
    write_xfer(cur_test, `I2C_ADDR, 1 + $urandom % 6);
    report_test(cur_test, mark);

    cur_test = "read";
    mark = errs;
    load_tx(i2c_byte_t'($urandom));
    @(negedge clk);
    if (tx_busy !== 1'b1) begin
      report_error(cur_test, "tx_busy_o low after loading a byte");
    end
    read_xfer(cur_test, 2 + $urandom % 5);
    if (tx_busy !== 1'b0) begin
      report_error(cur_test, "tx_busy_o still high after the byte was sent");
    end
    report_test(cur_test, mark);

    cur_test = "stop mid byte";
    mark = errs;
    return_credits(`I2C_RX_CREDITS);
    cmd_mark = cmd_count;
    start_cond();
    send_byte({`I2C_ADDR, 1'b0}, ack);
    check_ack({cur_test, " addr"}, ACK, ack);
    repeat (1 + $urandom % 6) begin
      clock_bit(1'($urandom), s);
    end
    stop_cond();
    check_cmd(cur_test, cmd_mark, 1'b1, 1'b0);
    write_xfer(cur_test, `I2C_ADDR, 1 + $urandom % 6);
    report_test(cur_test, mark);

    wait_clks(20);
    $display("tests: %0d, checks: %0d, errors: %0d", tests, checks, errs);
    if (errs == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

//--- i2c_target.f
+incdir+include
verilog/i2c_pkg.sv
verilog/i2c_bit_if.sv
verilog/i2c_line_decode.sv
verilog/i2c_bit_phy.sv
verilog/i2c_byte_engine.sv
verilog/i2c_byte_port.sv
verilog/i2c_target_top.sv
tests/tb_clock_gen.sv
tests/i2c_target_tb.sv

//--- Makefile
# Verilator build and run for the i2c target testbench

VERILATOR  ?= verilator
TOP        ?= i2c_target_tb
FILELIST   ?= i2c_target.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -Wno-fatal
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "simulation did not finish"; exit 1; fi

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
